//--- logic/membus_pkg.sv
`default_nettype none

package membus_pkg;

   ////////////////////////////////////////////////////////////
   // bus geometry and address map
   ////////////////////////////////////////////////////////////

   localparam int unsigned bus_addr_bits = 30;               // word address, byte offset dropped

   localparam int unsigned mem_words      = 1024;            // data/instruction memory depth
   localparam int unsigned mem_index_bits = $clog2(mem_words);

   localparam logic [bus_addr_bits-1:0] mem_base  = '0;      // first word of the memory
   localparam logic [bus_addr_bits-1:0] uart_addr = 30'h800; // single uart register

   ////////////////////////////////////////////////////////////
   // uart transmitter timing
   ////////////////////////////////////////////////////////////

   localparam int unsigned uart_bit_cycles = 8;              // clocks per serial bit
   localparam int unsigned uart_cnt_bits   = $clog2(uart_bit_cycles);
   localparam int unsigned uart_frame_bits = 10;             // start, 8 data, stop
   localparam int unsigned uart_idx_bits   = $clog2(uart_frame_bits);

   ////////////////////////////////////////////////////////////
   // memory word, whole or split into byte lanes
   ////////////////////////////////////////////////////////////

   typedef union packed {
      logic [31:0]     word;                                 // full 32-bit value
      logic [3:0][7:0] bytes;                                // lane 0 is bits 7:0
   } mem_word_u;

endpackage

`default_nettype wire

//--- logic/master_bus_mux.sv
`default_nettype none

module master_bus_mux (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic                                 use_probe,

   input  logic [membus_pkg::bus_addr_bits-1:0] probe_address,
   input  logic                                 probe_mem_read,
   input  logic                                 probe_mem_write,
   input  logic [3:0]                           probe_mask_byte,
   input  logic [31:0]                          probe_write_data,
   output logic [31:0]                          probe_read_data,

   input  logic [membus_pkg::bus_addr_bits-1:0] cpu_address,
   input  logic                                 cpu_mem_read,
   input  logic                                 cpu_mem_write,
   input  logic [3:0]                           cpu_mask_byte,
   input  logic [31:0]                          cpu_write_data,
   output logic [31:0]                          cpu_read_data,

   output logic [membus_pkg::bus_addr_bits-1:0] bus_address,
   output logic                                 bus_mem_read,
   output logic                                 bus_mem_write,
   output logic [3:0]                           bus_mask_byte,
   output logic [31:0]                          bus_write_data,
   input  logic [31:0]                          bus_read_data
);

   logic probe_read_q;                        // last read came from the probe

   ////////////////////////////////////////////////////////////
   // command path, no latency
   ////////////////////////////////////////////////////////////

   assign bus_address    = use_probe ? probe_address    : cpu_address;
   assign bus_mem_read   = use_probe ? probe_mem_read   : cpu_mem_read;
   assign bus_mem_write  = use_probe ? probe_mem_write  : cpu_mem_write;
   assign bus_mask_byte  = use_probe ? probe_mask_byte  : cpu_mask_byte;
   assign bus_write_data = use_probe ? probe_write_data : cpu_write_data;

   ////////////////////////////////////////////////////////////
   // return path, steered by the owner of the last read
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         probe_read_q <= 1'b0;
      end else if (bus_mem_read) begin
         probe_read_q <= use_probe;           // remember who asked
      end
   end

   // slaves drive zero outside a read return, so only the owner sees data
   assign probe_read_data = probe_read_q  ? bus_read_data : '0;
   assign cpu_read_data   = !probe_read_q ? bus_read_data : '0;

endmodule

`default_nettype wire

//--- logic/slave_bus_mux.sv
`default_nettype none

module slave_bus_mux (
   input  logic                                 clk,
   input  logic                                 arst_n,

   input  logic [membus_pkg::bus_addr_bits-1:0] address,
   input  logic                                 mem_read,
   input  logic                                 mem_write,
   input  logic [3:0]                           mask_byte,
   input  logic [31:0]                          write_data,
   output logic [31:0]                          read_data,
   output logic                                 invalid_address,

   output logic [membus_pkg::bus_addr_bits-1:0] mem_address,
   output logic                                 mem_mem_read,
   output logic                                 mem_mem_write,
   output logic [3:0]                           mem_mask_byte,
   output logic [31:0]                          mem_write_data,
   input  logic [31:0]                          mem_read_data,

   output logic                                 uart_mem_read,
   output logic                                 uart_mem_write,
   output logic [3:0]                           uart_mask_byte,
   output logic [31:0]                          uart_write_data,
   input  logic [31:0]                          uart_read_data
);

   logic [membus_pkg::bus_addr_bits-1:0] mem_offset;   // address relative to memory base
   logic                                 hit_mem;
   logic                                 hit_uart;
   logic                                 miss;
   logic                                 uart_sel_q;   // last read went to the uart

   ////////////////////////////////////////////////////////////
   // address decode
   ////////////////////////////////////////////////////////////

   assign mem_offset = address - membus_pkg::mem_base;
   assign hit_mem    = mem_offset < membus_pkg::mem_words;   // wraps below base, so one compare
   assign hit_uart   = address == membus_pkg::uart_addr;
   assign miss       = !hit_mem && !hit_uart;

   // memory side
   assign mem_address    = mem_offset;
   assign mem_mem_read   = mem_read  && hit_mem;
   assign mem_mem_write  = mem_write && hit_mem;
   assign mem_mask_byte  = mask_byte;
   assign mem_write_data = write_data;

   // uart side, a single register so no address
   assign uart_mem_read   = mem_read  && hit_uart;
   assign uart_mem_write  = mem_write && hit_uart;
   assign uart_mask_byte  = mask_byte;
   assign uart_write_data = write_data;

   ////////////////////////////////////////////////////////////
   // return select and miss flag
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         uart_sel_q      <= 1'b0;
         invalid_address <= 1'b0;
      end else begin
         if (mem_read) begin
            uart_sel_q <= hit_uart;
         end
         invalid_address <= (mem_read || mem_write) && miss;   // one cycle per bad command
      end
   end

   // an unmapped read strobes neither slave, both return zero
   assign read_data = uart_sel_q ? uart_read_data : mem_read_data;

endmodule

`default_nettype wire

//--- logic/data_mem.sv
`default_nettype none

module data_mem (
   input  logic                                 clk,
   input  logic                                 arst_n,

   input  logic [membus_pkg::bus_addr_bits-1:0] address,
   input  logic                                 mem_read,
   input  logic                                 mem_write,
   input  logic [3:0]                           mask_byte,
   input  logic [31:0]                          write_data,
   output logic [31:0]                          read_data,

   input  logic [31:0]                          pc,       // byte address
   output logic [31:0]                          instruction
);

   membus_pkg::mem_word_u mem [membus_pkg::mem_words];

   membus_pkg::mem_word_u                   wr_word;
   logic [membus_pkg::mem_index_bits-1:0]   data_idx;
   logic [membus_pkg::mem_index_bits-1:0]   fetch_idx;

   assign wr_word.word = write_data;
   assign data_idx     = address[membus_pkg::mem_index_bits-1:0];
   assign fetch_idx    = pc[membus_pkg::mem_index_bits+1:2];   // drop byte offset

   ////////////////////////////////////////////////////////////
   // byte-masked write port
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (mem_write) begin
         for (int b = 0; b < 4; b++) begin
            if (mask_byte[b]) begin
               mem[data_idx].bytes[b] <= wr_word.bytes[b];
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // registered data and fetch reads
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         read_data   <= '0;
         instruction <= '0;
      end else begin
         read_data   <= mem_read ? mem[data_idx].word : '0;   // zero when idle
         instruction <= mem[fetch_idx].word;
      end
   end

endmodule

`default_nettype wire

//--- logic/uart_port.sv
`default_nettype none

module uart_port (
   input  logic        clk,
   input  logic        arst_n,

   input  logic        mem_read,
   input  logic        mem_write,
   input  logic [3:0]  mask_byte,
   input  logic [31:0] write_data,
   output logic [31:0] read_data,

   output logic        uart_tx
);

   membus_pkg::mem_word_u                  wr_word;
   logic                                   start;
   logic                                   busy;
   logic                                   bit_done;
   logic [membus_pkg::uart_cnt_bits-1:0]   cycle_cnt;   // clocks within current bit
   logic [membus_pkg::uart_idx_bits-1:0]   bit_idx;     // 0 is the start bit
   logic [8:0]                             shift_q;     // data bits then stop bit

   assign wr_word.word = write_data;
   assign start        = mem_write && mask_byte[0] && !busy;   // busy writes are dropped
   assign bit_done     = cycle_cnt == membus_pkg::uart_bit_cycles - 1;

   ////////////////////////////////////////////////////////////
   // transmitter
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy      <= 1'b0;
         uart_tx   <= 1'b1;                  // line idles high
         cycle_cnt <= '0;
         bit_idx   <= '0;
         shift_q   <= '1;
      end else if (start) begin
         busy      <= 1'b1;
         uart_tx   <= 1'b0;                  // start bit on the next clock
         cycle_cnt <= '0;
         bit_idx   <= '0;
         shift_q   <= {1'b1, wr_word.bytes[0]};
      end else if (busy) begin
         cycle_cnt <= cycle_cnt + 1'b1;
         if (bit_done) begin
            cycle_cnt <= '0;
            if (bit_idx == membus_pkg::uart_frame_bits - 1) begin
               busy    <= 1'b0;              // stop bit finished
               uart_tx <= 1'b1;
            end else begin
               bit_idx <= bit_idx + 1'b1;
               uart_tx <= shift_q[0];        // lsb first
               shift_q <= {1'b1, shift_q[8:1]};
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // status read
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         read_data <= '0;
      end else begin
         read_data <= mem_read ? {31'b0, busy} : '0;   // busy as seen at the command
      end
   end

endmodule

`default_nettype wire

//--- logic/mem_platform.sv
`default_nettype none

module mem_platform (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic                                 probe_mem,   // probe owns the bus

   input  logic [membus_pkg::bus_addr_bits-1:0] probe_address,
   input  logic                                 probe_mem_read,
   input  logic                                 probe_mem_write,
   input  logic [3:0]                           probe_mask_byte,
   input  logic [31:0]                          probe_write_data,
   output logic [31:0]                          probe_read_data,

   input  logic [membus_pkg::bus_addr_bits-1:0] cpu_address,
   input  logic                                 cpu_mem_read,
   input  logic                                 cpu_mem_write,
   input  logic [3:0]                           cpu_mask_byte,
   input  logic [31:0]                          cpu_write_data,
   output logic [31:0]                          cpu_read_data,

   input  logic [31:0]                          pc,
   output logic [31:0]                          instruction,
   output logic                                 invalid_address,
   output logic                                 uart_tx
);

   // common bus after master selection
   logic [membus_pkg::bus_addr_bits-1:0] memory_address;
   logic                                 memory_mem_read;
   logic                                 memory_mem_write;
   logic [3:0]                           memory_mask_byte;
   logic [31:0]                          memory_write_data;
   logic [31:0]                          memory_read_data;

   // memory slave bus
   logic [membus_pkg::bus_addr_bits-1:0] data_address;
   logic                                 data_mem_read;
   logic                                 data_mem_write;
   logic [3:0]                           data_mask_byte;
   logic [31:0]                          data_write_data;
   logic [31:0]                          data_read_data;

   // uart slave bus
   logic                                 uart_mem_read;
   logic                                 uart_mem_write;
   logic [3:0]                           uart_mask_byte;
   logic [31:0]                          uart_write_data;
   logic [31:0]                          uart_read_data;

   ////////////////////////////////////////////////////////////
   // bus fabric
   ////////////////////////////////////////////////////////////

   master_bus_mux i_master_bus_mux (
      .clk, .arst_n,
      .use_probe        (probe_mem),
      .probe_address, .probe_mem_read, .probe_mem_write,
      .probe_mask_byte, .probe_write_data, .probe_read_data,
      .cpu_address, .cpu_mem_read, .cpu_mem_write,
      .cpu_mask_byte, .cpu_write_data, .cpu_read_data,
      .bus_address      (memory_address),
      .bus_mem_read     (memory_mem_read),
      .bus_mem_write    (memory_mem_write),
      .bus_mask_byte    (memory_mask_byte),
      .bus_write_data   (memory_write_data),
      .bus_read_data    (memory_read_data)
   );

   slave_bus_mux i_slave_bus_mux (
      .clk, .arst_n,
      .address          (memory_address),
      .mem_read         (memory_mem_read),
      .mem_write        (memory_mem_write),
      .mask_byte        (memory_mask_byte),
      .write_data       (memory_write_data),
      .read_data        (memory_read_data),
      .invalid_address,
      .mem_address      (data_address),
      .mem_mem_read     (data_mem_read),
      .mem_mem_write    (data_mem_write),
      .mem_mask_byte    (data_mask_byte),
      .mem_write_data   (data_write_data),
      .mem_read_data    (data_read_data),
      .uart_mem_read, .uart_mem_write, .uart_mask_byte,
      .uart_write_data, .uart_read_data
   );

   ////////////////////////////////////////////////////////////
   // slaves
   ////////////////////////////////////////////////////////////

   data_mem i_data_mem (
      .clk, .arst_n,
      .address          (data_address),
      .mem_read         (data_mem_read),
      .mem_write        (data_mem_write),
      .mask_byte        (data_mask_byte),
      .write_data       (data_write_data),
      .read_data        (data_read_data),
      .pc, .instruction
   );

   uart_port i_uart_port (
      .clk, .arst_n,
      .mem_read         (uart_mem_read),
      .mem_write        (uart_mem_write),
      .mask_byte        (uart_mask_byte),
      .write_data       (uart_write_data),
      .read_data        (uart_read_data),
      .uart_tx
   );

endmodule

`default_nettype wire

//--- tb/mem_platform_tb.sv
`default_nettype none

module mem_platform_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int aw           = membus_pkg::bus_addr_bits;
   localparam int clk_period   = 100;
   localparam int drive_delay  = 10;
   localparam int bit_cycles   = membus_pkg::uart_bit_cycles;
   localparam int frame_bits   = 10;                     // start, 8 data, stop
   localparam int n_rw         = 200;
   localparam int n_cpu        = 64;
   localparam int n_fetch      = 200;
   localparam int n_bad        = 40;
   localparam int frame_slots  = 12 * bit_cycles;        // frame plus idle tail
   localparam int test_cycles  = 12 + membus_pkg::mem_words + 2 * n_rw + 4 * n_cpu
                                 + n_fetch + n_bad + 2 + frame_slots + 2;
   localparam int limit_cycles = 2 * test_cycles;

   logic          clk;
   logic          arst_n;
   logic          probe_mem;
   logic [aw-1:0] probe_address;
   logic          probe_mem_read;
   logic          probe_mem_write;
   logic [3:0]    probe_mask_byte;
   logic [31:0]   probe_write_data;
   logic [31:0]   probe_read_data;
   logic [aw-1:0] cpu_address;
   logic          cpu_mem_read;
   logic          cpu_mem_write;
   logic [3:0]    cpu_mask_byte;
   logic [31:0]   cpu_write_data;
   logic [31:0]   cpu_read_data;
   logic [31:0]   pc;
   logic [31:0]   instruction;
   logic          invalid_address;
   logic          uart_tx;

   logic [31:0]   model [membus_pkg::mem_words];         // expected memory contents
   logic [31:0]   lfsr = 32'hda57_12cb;
   logic [aw-1:0] addr_q [$];
   logic [31:0]   exp_probe_next;
   logic [31:0]   exp_probe_q;
   logic [31:0]   exp_cpu_next;
   logic [31:0]   exp_cpu_q;
   logic [31:0]   exp_instr_next;
   logic [31:0]   exp_instr_q;
   logic          exp_inv_next;
   logic          exp_inv_q;
   logic          instr_chk_next;
   logic          instr_chk_q;
   logic          tx_chk;                                // sample uart_tx at the next edge
   logic          exp_tx;
   logic          tx_busy;                               // expected uart status bit

   mem_platform i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // x^32 + x^22 + x^2 + x + 1
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [3:0] m,
                                               input logic [31:0] d);
      logic [31:0] w;
      w = old;
      for (int b = 0; b < 4; b++) begin
         if (m[b]) begin
            w[8*b +: 8] = d[8*b +: 8];
         end
      end
      return w;
   endfunction

   function automatic logic in_mem(input logic [aw-1:0] a);
      return a >= membus_pkg::mem_base && a - membus_pkg::mem_base < membus_pkg::mem_words;
   endfunction

   task automatic fail_run(input string line);
      $display("%s", line);
      $display("test failed");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic clear_inputs();
      probe_address    = '0;
      probe_mem_read   = 1'b0;
      probe_mem_write  = 1'b0;
      probe_mask_byte  = '0;
      probe_write_data = '0;
      cpu_address      = '0;
      cpu_mem_read     = 1'b0;
      cpu_mem_write    = 1'b0;
      cpu_mask_byte    = '0;
      cpu_write_data   = '0;
      exp_probe_next   = '0;
      exp_cpu_next     = '0;
      exp_instr_next   = '0;
      exp_inv_next     = 1'b0;
      instr_chk_next   = 1'b0;
      tx_chk           = 1'b0;
   endtask

   task automatic step();
      @(posedge clk);
      #drive_delay;
      clear_inputs();
   endtask

   // drive one command and predict what comes back a cycle later
   task automatic issue(input logic by_probe, input logic rd, input logic wr,
                        input logic [aw-1:0] a, input logic [3:0] m, input logic [31:0] d);
      logic [31:0] rd_val;
      int          idx;
      idx    = int'(a - membus_pkg::mem_base);
      rd_val = '0;
      if (by_probe) begin
         probe_address    = a;
         probe_mem_read   = rd;
         probe_mem_write  = wr;
         probe_mask_byte  = m;
         probe_write_data = d;
      end else begin
         cpu_address    = a;
         cpu_mem_read   = rd;
         cpu_mem_write  = wr;
         cpu_mask_byte  = m;
         cpu_write_data = d;
      end
      if (in_mem(a)) begin
         rd_val = model[idx];
      end else if (a == membus_pkg::uart_addr) begin
         rd_val = {31'b0, tx_busy};
      end
      if (by_probe == probe_mem) begin                   // the other master is ignored
         if (rd && by_probe) begin
            exp_probe_next = rd_val;
         end
         if (rd && !by_probe) begin
            exp_cpu_next = rd_val;
         end
         exp_inv_next = (rd || wr) && !in_mem(a) && a != membus_pkg::uart_addr;
         if (wr && in_mem(a)) begin
            model[idx] = merge_bytes(model[idx], m, d);
         end
      end
   endtask

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         exp_probe_q <= '0;
         exp_cpu_q   <= '0;
         exp_instr_q <= '0;
         exp_inv_q   <= 1'b0;
         instr_chk_q <= 1'b0;
      end else begin
         exp_probe_q <= exp_probe_next;
         exp_cpu_q   <= exp_cpu_next;
         exp_instr_q <= exp_instr_next;
         exp_inv_q   <= exp_inv_next;
         instr_chk_q <= instr_chk_next;
      end
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   probe_data_check: assert property (@(posedge clk) disable iff (!arst_n)
      probe_read_data == exp_probe_q)
      else fail_run($sformatf("Mismatch at %0d ns: probe_read_data %h, expected %h",
                              $time, $sampled(probe_read_data), $sampled(exp_probe_q)));

   cpu_data_check: assert property (@(posedge clk) disable iff (!arst_n)
      cpu_read_data == exp_cpu_q)
      else fail_run($sformatf("Mismatch at %0d ns: cpu_read_data %h, expected %h",
                              $time, $sampled(cpu_read_data), $sampled(exp_cpu_q)));

   invalid_flag_check: assert property (@(posedge clk) disable iff (!arst_n)
      invalid_address == exp_inv_q)
      else fail_run($sformatf("Mismatch at %0d ns: invalid_address %b, expected %b",
                              $time, $sampled(invalid_address), $sampled(exp_inv_q)));

   fetch_check: assert property (@(posedge clk) disable iff (!arst_n)
      instr_chk_q |-> instruction == exp_instr_q)
      else fail_run($sformatf("Mismatch at %0d ns: instruction %h, expected %h",
                              $time, $sampled(instruction), $sampled(exp_instr_q)));

   serial_line_check: assert property (@(posedge clk) disable iff (!arst_n)
      tx_chk |-> uart_tx == exp_tx)
      else fail_run($sformatf("Mismatch at %0d ns: uart_tx %b, expected %b",
                              $time, $sampled(uart_tx), $sampled(exp_tx)));

   initial begin
      #(limit_cycles * clk_period);
      fail_run($sformatf("timeout: run still going after %0d clock cycles", limit_cycles));
   end

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////

   initial begin
      logic [aw-1:0] a;
      logic [3:0]    m;
      logic [31:0]   d;
      logic [7:0]    tx_byte;
      logic [9:0]    frame;
      logic          rd;
      clear_inputs();
      arst_n    = 1'b0;
      probe_mem = 1'b1;
      pc        = '0;
      tx_busy   = 1'b0;
      exp_tx    = 1'b1;
      repeat (10) step();
      arst_n = 1'b1;
      tx_chk = 1'b1;                                     // line idles high out of reset
      step();

      // fill every word so the fetch port never sees unknown data
      for (int i = 0; i < membus_pkg::mem_words; i++) begin
         issue(1'b1, 1'b0, 1'b1, membus_pkg::mem_base + aw'(i), 4'hf, 32'h9e37_79b9 * (i + 1));
         step();
      end

      // probe writes with random masks, then reads back
      for (int i = 0; i < n_rw; i++) begin
         a = membus_pkg::mem_base + aw'(take_bits(10));
         m = 4'(take_bits(4));
         d = take_bits(32);
         addr_q.push_back(a);
         issue(1'b1, 1'b0, 1'b1, a, m, d);
         step();
      end
      foreach (addr_q[i]) begin
         issue(1'b1, 1'b1, 1'b0, addr_q[i], 4'h0, '0);
         step();
      end

      // cpu owns the bus
      probe_mem = 1'b0;
      addr_q.delete();
      for (int i = 0; i < n_cpu; i++) begin
         a = membus_pkg::mem_base + aw'(take_bits(10));
         m = 4'(take_bits(4));
         d = take_bits(32);
         addr_q.push_back(a);
         issue(1'b0, 1'b0, 1'b1, a, m, d);
         step();
      end
      foreach (addr_q[i]) begin
         issue(1'b0, 1'b1, 1'b0, addr_q[i], 4'h0, '0);
         step();
      end

      // probe owns the bus so cpu writes must not land
      probe_mem = 1'b1;
      addr_q.delete();
      for (int i = 0; i < n_cpu; i++) begin
         a = membus_pkg::mem_base + aw'(take_bits(10));
         d = take_bits(32);
         addr_q.push_back(a);
         issue(1'b0, 1'b0, 1'b1, a, 4'hf, d);
         step();
      end
      foreach (addr_q[i]) begin
         issue(1'b1, 1'b1, 1'b0, addr_q[i], 4'h0, '0);
         step();
      end

      // instruction fetch at random byte addresses
      for (int i = 0; i < n_fetch; i++) begin
         pc             = take_bits(12);
         instr_chk_next = 1'b1;
         exp_instr_next = model[int'(pc / 4) - int'(membus_pkg::mem_base)];
         step();
      end

      // unmapped addresses
      for (int i = 0; i < n_bad; i++) begin
         a = aw'(take_bits(aw));
         if (in_mem(a) || a == membus_pkg::uart_addr) begin
            a[aw-1] = 1'b1;
         end
         rd = take_bits(1) != 0;
         d  = take_bits(32);
         issue(1'b1, rd, !rd, a, 4'hf, d);
         step();
      end
      issue(1'b1, 1'b1, 1'b0, membus_pkg::mem_base, 4'h0, '0);
      step();

      // one uart frame sampled mid-bit
      tx_byte = 8'(take_bits(8));
      d       = take_bits(3);
      m       = {d[2:0], 1'b1};
      d       = take_bits(24);
      d       = {d[23:0], tx_byte};
      frame   = {1'b1, tx_byte, 1'b0};                   // sent from bit 0 upward
      issue(1'b1, 1'b0, 1'b1, membus_pkg::uart_addr, m, d);
      step();
      tx_busy = 1'b1;
      for (int s = 0; s < frame_slots; s++) begin
         if (s % bit_cycles == bit_cycles / 2 - 1) begin
            tx_chk = 1'b1;
            exp_tx = (s / bit_cycles < frame_bits) ? frame[s / bit_cycles] : 1'b1;
         end
         if (s == 2 * bit_cycles + 4) begin
            issue(1'b1, 1'b1, 1'b0, membus_pkg::uart_addr, 4'h0, '0);
         end
         if (s == 4 * bit_cycles + 2) begin                // dropped while busy
            issue(1'b1, 1'b0, 1'b1, membus_pkg::uart_addr, 4'h1, {24'b0, ~tx_byte});
         end
         if (s == frame_bits * bit_cycles + 4) begin
            tx_busy = 1'b0;
            issue(1'b1, 1'b1, 1'b0, membus_pkg::uart_addr, 4'h0, '0);
         end
         step();
      end

      repeat (2) step();
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- mem_platform.f
logic/membus_pkg.sv
logic/master_bus_mux.sv
logic/slave_bus_mux.sv
logic/data_mem.sv
logic/uart_port.sv
logic/mem_platform.sv
tb/mem_platform_tb.sv

//--- Bender.yml
package:
  name: mem_platform

sources:
  - logic/membus_pkg.sv
  - logic/master_bus_mux.sv
  - logic/slave_bus_mux.sv
  - logic/data_mem.sv
  - logic/uart_port.sv
  - logic/mem_platform.sv
  - target: test
    files:
      - tb/mem_platform_tb.sv
